//--- lsu.f
design/lsu_pkg.sv
design/lsu_access_decode.sv
design/lsu_store_buffer.sv
design/lsu_data_ram.sv
design/lsu_load_align.sv
design/lsu_load_pipe.sv
design/lsu_exc_record.sv
design/lsu_top.sv
bench/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module lsu_tb -f lsu.f -o lsu_sim
if [ $? -ne 0 ]; then
    echo "verilator compile step failed"
    exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
exit 1

//--- bench/lsu_tb.sv
`default_nettype none

module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int SAMPLE_DLY = 2;

    logic       clk = 1'b0;
    logic       rst;
    logic       ld_valid;
    logic       ld_ready;
    logic       ld_uext;
    xdata_t     ld_base;
    imm_t       ld_imm;
    mem_size_t  ld_size;
    load_tag_t  ld_tag;
    logic       st_valid;
    logic       st_ready;
    xdata_t     st_base;
    xdata_t     st_data;
    imm_t       st_imm;
    mem_size_t  st_size;
    logic       rsp_valid;
    logic       rsp_ready;
    logic       rsp_exc;
    load_tag_t  rsp_tag;
    xdata_t     rsp_data;
    logic       exc_valid;
    logic       exc_clear;
    exc_cause_e exc_cause;
    vaddr_t     exc_vaddr;

    logic [7:0] ref_mem [RAM_DEPTH*LINE_BYTES] = '{default: '0};
    load_tag_t  exp_tag_q [$];
    xdata_t     exp_data_q [$];
    logic       exp_exc_q [$];
    load_tag_t  next_tag;
    integer     seed;
    int         n_errors = 0;
    int         n_checks = 0;
    int         n_req = 0;

    lsu_top i_dut (
        .clk, .rst,
        .ld_valid_i (ld_valid), .ld_ready_o (ld_ready), .ld_base_i (ld_base),
        .ld_imm_i (ld_imm), .ld_size_i (ld_size), .ld_uext_i (ld_uext), .ld_tag_i (ld_tag),
        .st_valid_i (st_valid), .st_ready_o (st_ready), .st_base_i (st_base),
        .st_imm_i (st_imm), .st_size_i (st_size), .st_data_i (st_data),
        .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready), .rsp_tag_o (rsp_tag),
        .rsp_data_o (rsp_data), .rsp_exc_o (rsp_exc),
        .exc_valid_o (exc_valid), .exc_cause_o (exc_cause), .exc_vaddr_o (exc_vaddr),
        .exc_clear_i (exc_clear)
    );

    always #5 clk = ~clk;

    task automatic check_data(string name, xdata_t exp, xdata_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_tag(string name, load_tag_t exp, load_tag_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_cause(string name, exc_cause_e exp, exc_cause_e act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
        end
    endtask

    task automatic check_addr(string name, vaddr_t exp, vaddr_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    function automatic xdata_t rand_data();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic vaddr_t calc_addr(xdata_t base, imm_t imm);
        xdata_t full;
        full = base + xdata_t'($signed(imm));
        return full[VADDR_W-1:0];
    endfunction

    // natural alignment including dword
    function automatic logic misaligned(vaddr_t a, mem_size_t sz);
        return (int'(a[OFFSET_W-1:0]) % (1 << sz)) != 0;
    endfunction

    function automatic void model_store(vaddr_t a, mem_size_t sz, xdata_t data);
        int base_idx;
        base_idx = int'(a[OFFSET_W+RAM_IDX_W-1:0]);
        if (!misaligned(a, sz)) begin
            for (int i = 0; i < (1 << sz); i++) begin
                ref_mem[base_idx + i] = data[8*i +: 8];
            end
        end
    endfunction

    function automatic xdata_t model_load(vaddr_t a, mem_size_t sz, logic uext);
        xdata_t val;
        int     base_idx;
        int     nbytes;
        val      = '0;
        nbytes   = 1 << sz;
        base_idx = int'(a[OFFSET_W+RAM_IDX_W-1:0]);
        if (!misaligned(a, sz)) begin
            for (int i = 0; i < nbytes; i++) begin
                val[8*i +: 8] = ref_mem[base_idx + i];
            end
            if (!uext && val[8*nbytes-1]) begin
                for (int i = 8 * nbytes; i < XLEN; i++) begin
                    val[i] = 1'b1;
                end
            end
        end
        return val;
    endfunction

    // stores go first so a same-cycle store counts as older
    always begin
        @(negedge clk);
        #SAMPLE_DLY;
        if (rst) begin
            if (st_valid && st_ready) begin
                model_store(calc_addr(st_base, st_imm), st_size, st_data);
            end
            if (ld_valid && ld_ready) begin
                exp_tag_q.push_back(ld_tag);
                exp_data_q.push_back(model_load(calc_addr(ld_base, ld_imm), ld_size, ld_uext));
                exp_exc_q.push_back(misaligned(calc_addr(ld_base, ld_imm), ld_size));
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_tag_q.size() == 0) begin
                    n_errors++;
                    $display("a load response appeared at %0t with no load pending", $time);
                end else begin
                    check_tag("rsp_tag_o", exp_tag_q.pop_front(), rsp_tag);
                    check_data("rsp_data_o", exp_data_q.pop_front(), rsp_data);
                    check_flag("rsp_exc_o", exp_exc_q.pop_front(), rsp_exc);
                end
            end
        end
    end

    // starts at a falling edge and returns at the one after the accept
    task automatic load_req(xdata_t base, imm_t imm, mem_size_t sz, logic uext);
        n_req++;
        ld_valid = 1'b1;
        ld_base  = base;
        ld_imm   = imm;
        ld_size  = sz;
        ld_uext  = uext;
        ld_tag   = next_tag;
        next_tag++;
        #SAMPLE_DLY;
        while (!ld_ready) begin
            @(negedge clk);
            #SAMPLE_DLY;
        end
        @(negedge clk);
        ld_valid = 1'b0;
    endtask

    task automatic store_req(xdata_t base, imm_t imm, mem_size_t sz, xdata_t data);
        n_req++;
        st_valid = 1'b1;
        st_base  = base;
        st_imm   = imm;
        st_size  = sz;
        st_data  = data;
        #SAMPLE_DLY;
        while (!st_ready) begin
            @(negedge clk);
            #SAMPLE_DLY;
        end
        @(negedge clk);
        st_valid = 1'b0;
    endtask

    task automatic idle(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic drain_rsp();
        while (exp_tag_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic access_sizes();
        mem_size_t sz;
        xdata_t    base;
        xdata_t    data;
        imm_t      imm;
        int        off;
        for (int i = 0; i < 8; i++) begin
            sz   = mem_size_t'(i % 4);
            off  = ((i * 3) << int'(sz)) % 8;
            imm  = (i % 2 == 0) ? imm_t'(-24) : imm_t'(56);
            base = 64'hdead_0000_0000_0400 + 64'(8 * i + off);
            data = rand_data();
            data = (i < 4) ? (data | 64'h8080_8080_8080_8080) : (data & ~64'h8080_8080_8080_8080);
            store_req(base, imm, sz, data);
        end
        idle(SB_DEPTH);
        for (int i = 0; i < 8; i++) begin
            sz   = mem_size_t'(i % 4);
            off  = ((i * 3) << int'(sz)) % 8;
            imm  = (i % 2 == 0) ? imm_t'(-24) : imm_t'(56);
            base = 64'hdead_0000_0000_0400 + 64'(8 * i + off);
            load_req(base, imm, sz, 1'b0);
            load_req(base, imm, sz, 1'b1);
            load_req(base & ~64'h7, imm, SZ_DWORD, 1'b0);
        end
        drain_rsp();
    endtask

    task automatic store_forwarding();
        xdata_t base;
        base = 64'h0000_0000_0000_0500;
        fork
            store_req(base, imm_t'(0), SZ_DWORD, rand_data());
            load_req(base, imm_t'(0), SZ_DWORD, 1'b0);
        join
        // reads in flight hold the partial stores in the buffer
        fork
            begin
                store_req(base, imm_t'(8), SZ_WORD, rand_data());
                store_req(base, imm_t'(10), SZ_HALF, rand_data());
                store_req(base, imm_t'(11), SZ_BYTE, rand_data());
            end
            begin
                load_req(base, imm_t'(64), SZ_DWORD, 1'b0);
                load_req(base, imm_t'(72), SZ_DWORD, 1'b0);
                load_req(base, imm_t'(8), SZ_DWORD, 1'b0);
            end
        join
        load_req(base, imm_t'(8), SZ_DWORD, 1'b1);
        load_req(base, imm_t'(10), SZ_HALF, 1'b0);
        load_req(base, imm_t'(8), SZ_WORD, 1'b1);
        drain_rsp();
        idle(SB_DEPTH);
    endtask

    task automatic response_backpressure();
        load_req(64'h408, imm_t'(0), SZ_DWORD, 1'b0);
        #SAMPLE_DLY;
        check_flag("rsp_valid_o", 1'b0, rsp_valid);
        @(negedge clk);
        #SAMPLE_DLY;
        check_flag("rsp_valid_o", 1'b1, rsp_valid);
        @(negedge clk);
        rsp_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    load_req(64'h400 + 64'(8 * i), imm_t'(0), SZ_DWORD, 1'b0);
                end
            end
            begin
                #SAMPLE_DLY;
                while (ld_ready) begin
                    @(negedge clk);
                    #SAMPLE_DLY;
                end
                repeat (3) @(negedge clk);
                #SAMPLE_DLY;
                check_flag("ld_ready_o", 1'b0, ld_ready);
                check_flag("rsp_valid_o", 1'b1, rsp_valid);
                @(negedge clk);
                rsp_ready = 1'b1;
            end
        join
        drain_rsp();
    endtask

    task automatic drain_starvation();
        fork
            begin
                for (int i = 0; i < 10; i++) begin
                    load_req(64'h600 + 64'(8 * i), imm_t'(0), SZ_DWORD, 1'b0);
                end
            end
            begin
                for (int i = 0; i < SB_DEPTH; i++) begin
                    store_req(64'h600 + 64'(8 * i), imm_t'(0), SZ_DWORD, rand_data());
                end
                #SAMPLE_DLY;
                check_flag("st_ready_o", 1'b0, st_ready);
            end
        join
        drain_rsp();
        idle(SB_DEPTH + 1);
        #SAMPLE_DLY;
        check_flag("st_ready_o", 1'b1, st_ready);
        @(negedge clk);
        for (int i = 0; i < SB_DEPTH; i++) begin
            load_req(64'h600 + 64'(8 * i), imm_t'(0), SZ_DWORD, 1'b0);
        end
        drain_rsp();
    endtask

    task automatic misalign_exceptions();
        store_req(64'h700, imm_t'(0), SZ_DWORD, rand_data());
        store_req(64'h708, imm_t'(0), SZ_DWORD, rand_data());
        load_req(64'h6ff, imm_t'(2), SZ_HALF, 1'b0);
        drain_rsp();
        #SAMPLE_DLY;
        check_flag("exc_valid_o", 1'b1, exc_valid);
        check_cause("exc_cause_o", EXC_LAM, exc_cause);
        check_addr("exc_vaddr_o", 16'h0701, exc_vaddr);
        @(negedge clk);
        // record is full so this one is dropped
        store_req(64'h700, imm_t'(2), SZ_WORD, rand_data());
        #SAMPLE_DLY;
        check_cause("exc_cause_o", EXC_LAM, exc_cause);
        check_addr("exc_vaddr_o", 16'h0701, exc_vaddr);
        @(negedge clk);
        exc_clear = 1'b1;
        @(negedge clk);
        exc_clear = 1'b0;
        #SAMPLE_DLY;
        check_flag("exc_valid_o", 1'b0, exc_valid);
        @(negedge clk);
        store_req(64'h708, imm_t'(-4), SZ_DWORD, rand_data());
        #SAMPLE_DLY;
        check_flag("exc_valid_o", 1'b1, exc_valid);
        check_cause("exc_cause_o", EXC_SAM, exc_cause);
        check_addr("exc_vaddr_o", 16'h0704, exc_vaddr);
        @(negedge clk);
        load_req(64'h700, imm_t'(0), SZ_DWORD, 1'b0);
        load_req(64'h708, imm_t'(0), SZ_DWORD, 1'b0);
        drain_rsp();
    endtask

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < 20 * n_req + 200) begin
            @(negedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed      = 9;
        next_tag  = '0;
        rst       = 1'b0;
        ld_valid  = 1'b0;
        ld_base   = '0;
        ld_imm    = '0;
        ld_size   = SZ_BYTE;
        ld_uext   = 1'b0;
        ld_tag    = '0;
        st_valid  = 1'b0;
        st_base   = '0;
        st_imm    = '0;
        st_size   = SZ_BYTE;
        st_data   = '0;
        rsp_ready = 1'b1;
        exc_clear = 1'b0;
        @(negedge clk);
        #SAMPLE_DLY;
        check_flag("ld_ready_o", 1'b0, ld_ready);
        check_flag("st_ready_o", 1'b1, st_ready);
        check_flag("rsp_valid_o", 1'b0, rsp_valid);
        check_flag("exc_valid_o", 1'b0, exc_valid);
        repeat (2) @(negedge clk);
        rst = 1'b1;
        access_sizes();
        store_forwarding();
        response_backpressure();
        drain_starvation();
        misalign_exceptions();
        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/lsu_top.sv
`default_nettype none

module lsu_top (
    input  wire                  clk,
    input  wire                  rst,
    input  logic                 ld_valid_i,
    output logic                 ld_ready_o,
    input  lsu_pkg::xdata_t      ld_base_i,
    input  lsu_pkg::imm_t        ld_imm_i,
    input  lsu_pkg::mem_size_t   ld_size_i,
    input  logic                 ld_uext_i,
    input  lsu_pkg::load_tag_t   ld_tag_i,
    input  logic                 st_valid_i,
    output logic                 st_ready_o,
    input  lsu_pkg::xdata_t      st_base_i,
    input  lsu_pkg::imm_t        st_imm_i,
    input  lsu_pkg::mem_size_t   st_size_i,
    input  lsu_pkg::xdata_t      st_data_i,
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    output lsu_pkg::load_tag_t   rsp_tag_o,
    output lsu_pkg::xdata_t      rsp_data_o,
    output logic                 rsp_exc_o,
    output logic                 exc_valid_o,
    output lsu_pkg::exc_cause_e  exc_cause_o,
    output lsu_pkg::vaddr_t      exc_vaddr_o,
    input  logic                 exc_clear_i
);
    import lsu_pkg::*;

    vaddr_t   ld_vaddr;
    logic     ld_misalign;
    vaddr_t   st_vaddr;
    bmask_t   st_mask;
    logic     st_misalign;
    logic     rd_en;
    ram_idx_t rd_idx;
    xdata_t   rd_data;
    logic     port_busy;
    ram_idx_t fwd_idx;
    bmask_t   fwd_mask;
    xdata_t   fwd_data;
    logic     wr_en;
    ram_idx_t wr_idx;
    bmask_t   wr_mask;
    xdata_t   wr_data;
    logic     ld_exc;
    vaddr_t   ld_exc_vaddr;
    logic     st_exc;
    vaddr_t   st_exc_vaddr;

    // the load side merges whole doublewords and takes no byte mask
    lsu_access_decode i_ld_decode (
        .base_i (ld_base_i), .imm_i (ld_imm_i), .size_i (ld_size_i),
        .vaddr_o (ld_vaddr), .mask_o (), .misalign_o (ld_misalign)
    );

    lsu_access_decode i_st_decode (
        .base_i (st_base_i), .imm_i (st_imm_i), .size_i (st_size_i),
        .vaddr_o (st_vaddr), .mask_o (st_mask), .misalign_o (st_misalign)
    );

    lsu_store_buffer i_store_buffer (
        .clk, .rst, .st_valid_i, .st_ready_o,
        .vaddr_i (st_vaddr), .mask_i (st_mask), .misalign_i (st_misalign),
        .data_i (st_data_i), .port_busy_i (port_busy),
        .fwd_idx_i (fwd_idx), .fwd_mask_o (fwd_mask), .fwd_data_o (fwd_data),
        .wr_en_o (wr_en), .wr_idx_o (wr_idx), .wr_mask_o (wr_mask), .wr_data_o (wr_data),
        .exc_valid_o (st_exc), .exc_vaddr_o (st_exc_vaddr)
    );

    lsu_data_ram i_data_ram (
        .clk, .rd_en_i (rd_en), .rd_idx_i (rd_idx), .rd_data_o (rd_data),
        .wr_en_i (wr_en), .wr_idx_i (wr_idx), .wr_mask_i (wr_mask), .wr_data_i (wr_data)
    );

    lsu_load_pipe i_load_pipe (
        .clk, .rst, .ld_valid_i, .ld_ready_o,
        .vaddr_i (ld_vaddr), .misalign_i (ld_misalign), .size_i (ld_size_i),
        .uext_i (ld_uext_i), .tag_i (ld_tag_i),
        .rd_en_o (rd_en), .rd_idx_o (rd_idx), .rd_data_i (rd_data), .port_busy_o (port_busy),
        .fwd_idx_o (fwd_idx), .fwd_mask_i (fwd_mask), .fwd_data_i (fwd_data),
        .rsp_valid_o, .rsp_ready_i, .rsp_tag_o, .rsp_data_o, .rsp_exc_o,
        .exc_valid_o (ld_exc), .exc_vaddr_o (ld_exc_vaddr)
    );

    lsu_exc_record i_exc_record (
        .clk, .rst, .ld_exc_i (ld_exc), .ld_vaddr_i (ld_exc_vaddr),
        .st_exc_i (st_exc), .st_vaddr_i (st_exc_vaddr), .clear_i (exc_clear_i),
        .exc_valid_o, .exc_cause_o, .exc_vaddr_o
    );

endmodule

`default_nettype wire

//--- design/lsu_exc_record.sv
`default_nettype none

module lsu_exc_record (
    input  wire                  clk,
    input  wire                  rst,
    input  logic                 ld_exc_i,
    input  lsu_pkg::vaddr_t      ld_vaddr_i,
    input  logic                 st_exc_i,
    input  lsu_pkg::vaddr_t      st_vaddr_i,
    input  logic                 clear_i,
    output logic                 exc_valid_o,
    output lsu_pkg::exc_cause_e  exc_cause_o,
    output lsu_pkg::vaddr_t      exc_vaddr_o
);
    import lsu_pkg::*;

    logic capture;

    // only an empty record takes a new report
    assign capture = ~exc_valid_o & ~clear_i & (ld_exc_i | st_exc_i);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            exc_valid_o <= 1'b0;
            exc_cause_o <= EXC_NONE;
        end else if (clear_i) begin
            exc_valid_o <= 1'b0;
            exc_cause_o <= EXC_NONE;
        end else if (capture) begin
            exc_valid_o <= 1'b1;
            exc_cause_o <= ld_exc_i ? EXC_LAM : EXC_SAM;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            exc_vaddr_o <= ld_exc_i ? ld_vaddr_i : st_vaddr_i;
        end
    end

endmodule

`default_nettype wire

//--- design/lsu_load_pipe.sv
`default_nettype none

module lsu_load_pipe (
    input  wire                 clk,
    input  wire                 rst,
    input  logic                ld_valid_i,
    output logic                ld_ready_o,
    input  lsu_pkg::vaddr_t     vaddr_i,
    input  logic                misalign_i,
    input  lsu_pkg::mem_size_t  size_i,
    input  logic                uext_i,
    input  lsu_pkg::load_tag_t  tag_i,
    output logic                rd_en_o,
    output lsu_pkg::ram_idx_t   rd_idx_o,
    input  lsu_pkg::xdata_t     rd_data_i,
    output logic                port_busy_o,
    output lsu_pkg::ram_idx_t   fwd_idx_o,
    input  lsu_pkg::bmask_t     fwd_mask_i,
    input  lsu_pkg::xdata_t     fwd_data_i,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output lsu_pkg::load_tag_t  rsp_tag_o,
    output lsu_pkg::xdata_t     rsp_data_o,
    output logic                rsp_exc_o,
    output logic                exc_valid_o,
    output lsu_pkg::vaddr_t     exc_vaddr_o
);
    import lsu_pkg::*;

    logic      init_q;
    logic      accept;
    logic      s2_valid_q;
    vaddr_t    s2_vaddr_q;
    logic      s2_misalign_q;
    mem_size_t s2_size_q;
    logic      s2_uext_q;
    load_tag_t s2_tag_q;
    xdata_t    merged;
    xdata_t    aligned;
    logic      pop;
    logic [2:0] credits_used;
    logic [1:0] fifo_cnt_q;
    logic       fifo_wr_q;
    logic       fifo_rd_q;
    load_tag_t  fifo_tag_q [RSP_DEPTH];
    xdata_t     fifo_data_q [RSP_DEPTH];
    logic       fifo_exc_q [RSP_DEPTH];

    // s2 plus fifo entries must leave room for the new load
    assign pop          = rsp_valid_o & rsp_ready_i;
    assign credits_used = {1'b0, fifo_cnt_q} + {2'b00, s2_valid_q} - {2'b00, pop};
    assign ld_ready_o   = init_q & (credits_used < 3'd2);
    assign accept       = ld_valid_i & ld_ready_o;

    assign rd_en_o     = accept & ~misalign_i;
    assign rd_idx_o    = vaddr_i[OFFSET_W+RAM_IDX_W-1:OFFSET_W];
    assign port_busy_o = rd_en_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            init_q     <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            init_q     <= 1'b1;
            s2_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s2_vaddr_q    <= vaddr_i;
            s2_misalign_q <= misalign_i;
            s2_size_q     <= size_i;
            s2_uext_q     <= uext_i;
            s2_tag_q      <= tag_i;
        end
    end

    // buffered store bytes win over memory in the second stage
    assign fwd_idx_o = s2_vaddr_q[OFFSET_W+RAM_IDX_W-1:OFFSET_W];

    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            merged[8*b +: 8] = fwd_mask_i[b] ? fwd_data_i[8*b +: 8] : rd_data_i[8*b +: 8];
        end
    end

    lsu_load_align i_align (
        .data_i   (merged),
        .offset_i (s2_vaddr_q[OFFSET_W-1:0]),
        .size_i   (s2_size_q),
        .uext_i   (s2_uext_q),
        .data_o   (aligned)
    );

    assign exc_valid_o = s2_valid_q & s2_misalign_q;
    assign exc_vaddr_o = s2_vaddr_q;

    // response fifo
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fifo_cnt_q <= '0;
            fifo_wr_q  <= 1'b0;
            fifo_rd_q  <= 1'b0;
        end else begin
            fifo_cnt_q <= fifo_cnt_q + {1'b0, s2_valid_q} - {1'b0, pop};
            if (s2_valid_q) begin
                fifo_wr_q <= ~fifo_wr_q;
            end
            if (pop) begin
                fifo_rd_q <= ~fifo_rd_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid_q) begin
            fifo_tag_q[fifo_wr_q]  <= s2_tag_q;
            fifo_data_q[fifo_wr_q] <= s2_misalign_q ? '0 : aligned;
            fifo_exc_q[fifo_wr_q]  <= s2_misalign_q;
        end
    end

    assign rsp_valid_o = fifo_cnt_q != 2'd0;
    assign rsp_tag_o   = fifo_tag_q[fifo_rd_q];
    assign rsp_data_o  = fifo_data_q[fifo_rd_q];
    assign rsp_exc_o   = fifo_exc_q[fifo_rd_q];

endmodule

`default_nettype wire

//--- design/lsu_load_align.sv
`default_nettype none

module lsu_load_align (
    input  lsu_pkg::xdata_t                 data_i,
    input  logic [lsu_pkg::OFFSET_W-1:0]    offset_i,
    input  lsu_pkg::mem_size_t              size_i,
    input  logic                            uext_i,
    output lsu_pkg::xdata_t                 data_o
);
    import lsu_pkg::*;

    logic [2*XLEN-1:0] doubled;
    xdata_t            rot;

    // rotate so the addressed byte lands at bit 0
    assign doubled = {data_i, data_i} >> {offset_i, 3'b000};
    assign rot     = doubled[XLEN-1:0];

    always_comb begin
        case (size_i)
            SZ_BYTE: data_o = {{(XLEN-8){~uext_i & rot[7]}}, rot[7:0]};
            SZ_HALF: data_o = {{(XLEN-16){~uext_i & rot[15]}}, rot[15:0]};
            SZ_WORD: data_o = {{(XLEN-32){~uext_i & rot[31]}}, rot[31:0]};
            default: data_o = rot;
        endcase
    end

endmodule

`default_nettype wire

//--- design/lsu_data_ram.sv
`default_nettype none

module lsu_data_ram (
    input  wire                clk,
    input  logic               rd_en_i,
    input  lsu_pkg::ram_idx_t  rd_idx_i,
    output lsu_pkg::xdata_t    rd_data_o,
    input  logic               wr_en_i,
    input  lsu_pkg::ram_idx_t  wr_idx_i,
    input  lsu_pkg::bmask_t    wr_mask_i,
    input  lsu_pkg::xdata_t    wr_data_i
);
    import lsu_pkg::*;

    xdata_t mem_q [RAM_DEPTH] = '{default: '0};

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (wr_mask_i[b]) begin
                    mem_q[wr_idx_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
        // output holds between reads
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_idx_i];
        end
    end

endmodule

`default_nettype wire

//--- design/lsu_store_buffer.sv
`default_nettype none

module lsu_store_buffer (
    input  wire                clk,
    input  wire                rst,
    input  logic               st_valid_i,
    output logic               st_ready_o,
    input  lsu_pkg::vaddr_t    vaddr_i,
    input  lsu_pkg::bmask_t    mask_i,
    input  logic               misalign_i,
    input  lsu_pkg::xdata_t    data_i,
    input  logic               port_busy_i,
    input  lsu_pkg::ram_idx_t  fwd_idx_i,
    output lsu_pkg::bmask_t    fwd_mask_o,
    output lsu_pkg::xdata_t    fwd_data_o,
    output logic               wr_en_o,
    output lsu_pkg::ram_idx_t  wr_idx_o,
    output lsu_pkg::bmask_t    wr_mask_o,
    output lsu_pkg::xdata_t    wr_data_o,
    output logic               exc_valid_o,
    output lsu_pkg::vaddr_t    exc_vaddr_o
);
    import lsu_pkg::*;

    logic [SB_DEPTH-1:0] valid_q;
    logic [SB_PTR_W-1:0] head_q;
    logic [SB_PTR_W-1:0] tail_q;
    ram_idx_t            idx_q [SB_DEPTH];
    bmask_t              mask_q [SB_DEPTH];
    xdata_t              data_q [SB_DEPTH];
    logic                accept;
    logic                push;

    assign st_ready_o  = ~valid_q[tail_q];
    assign accept      = st_valid_i & st_ready_o;
    // misaligned stores are taken but only reported
    assign push        = accept & ~misalign_i;
    assign exc_valid_o = accept & misalign_i;
    assign exc_vaddr_o = vaddr_i;

    assign wr_en_o   = valid_q[head_q] & ~port_busy_i;
    assign wr_idx_o  = idx_q[head_q];
    assign wr_mask_o = mask_q[head_q];
    assign wr_data_o = data_q[head_q];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (push) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= tail_q + 1'b1;
            end
            if (wr_en_o) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            idx_q[tail_q]  <= vaddr_i[OFFSET_W+RAM_IDX_W-1:OFFSET_W];
            mask_q[tail_q] <= mask_i;
            data_q[tail_q] <= data_i << {vaddr_i[OFFSET_W-1:0], 3'b000};
        end
    end

    // walk oldest to newest so younger bytes overwrite older ones
    always_comb begin
        logic [SB_PTR_W-1:0] slot;
        fwd_mask_o = '0;
        fwd_data_o = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            slot = head_q + SB_PTR_W'(i);
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (valid_q[slot] && idx_q[slot] == fwd_idx_i && mask_q[slot][b]) begin
                    fwd_mask_o[b]         = 1'b1;
                    fwd_data_o[8*b +: 8]  = data_q[slot][8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/lsu_access_decode.sv
`default_nettype none

module lsu_access_decode (
    input  lsu_pkg::xdata_t    base_i,
    input  lsu_pkg::imm_t      imm_i,
    input  lsu_pkg::mem_size_t size_i,
    output lsu_pkg::vaddr_t    vaddr_o,
    output lsu_pkg::bmask_t    mask_o,
    output logic               misalign_o
);
    import lsu_pkg::*;

    xdata_t                sum;
    logic [OFFSET_W-1:0]   offset;
    bmask_t                base_mask;

    assign sum     = base_i + {{(XLEN-$bits(imm_t)){imm_i[$bits(imm_t)-1]}}, imm_i};
    assign vaddr_o = sum[VADDR_W-1:0];
    assign offset  = vaddr_o[OFFSET_W-1:0];

    always_comb begin
        case (size_i)
            SZ_BYTE: base_mask = 8'h01;
            SZ_HALF: base_mask = 8'h03;
            SZ_WORD: base_mask = 8'h0f;
            default: base_mask = 8'hff;
        endcase
    end

    // bytes shifted past the top of the doubleword fall off
    assign mask_o = base_mask << offset;

    always_comb begin
        case (size_i)
            SZ_HALF:  misalign_o = offset[0];
            SZ_WORD:  misalign_o = |offset[1:0];
            SZ_DWORD: misalign_o = |offset;
            default:  misalign_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int XLEN       = 64;
    localparam int VADDR_W    = 16;
    localparam int LINE_BYTES = 8;
    localparam int OFFSET_W   = 3;
    localparam int RAM_DEPTH  = 64;
    localparam int RAM_IDX_W  = 6;
    localparam int SB_DEPTH   = 4;
    localparam int SB_PTR_W   = 2;
    localparam int RSP_DEPTH  = 2;
    localparam int TAG_W      = 4;

    typedef logic [XLEN-1:0]       xdata_t;
    typedef logic [VADDR_W-1:0]    vaddr_t;
    typedef logic [11:0]           imm_t;
    typedef logic [LINE_BYTES-1:0] bmask_t;
    typedef logic [RAM_IDX_W-1:0]  ram_idx_t;
    typedef logic [1:0]            mem_size_t;
    typedef logic [TAG_W-1:0]      load_tag_t;

    // access size codes
    localparam mem_size_t SZ_BYTE  = 2'b00;
    localparam mem_size_t SZ_HALF  = 2'b01;
    localparam mem_size_t SZ_WORD  = 2'b10;
    localparam mem_size_t SZ_DWORD = 2'b11;

    // risc-v mcause values for misaligned access
    typedef enum logic [3:0] {
        EXC_NONE = 4'd0,
        EXC_LAM  = 4'd4,
        EXC_SAM  = 4'd6
    } exc_cause_e;

endpackage

`default_nettype wire
